// File: Makefile
# Verilator simulation of the Sv32 data MMU, run from the project root
TOP := tb_sv32_mmu

sim:
	verilator --binary --timing -Wno-fatal -f sim.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean

// File: dv/mmu_golden.hex
// Sv32 page table image and translation vectors, eight hex words per line
// kind 1 PTE memory: kind pte_addr pte_data err 0 0 0 0
// kind 2 vector: kind name ctrl(xen priv sum mxr flush) vaddr store paddr exp(exc cause) mem_reqs
// root table at PPN 00100, second level table at PPN 00101, priv 1 is S and 0 is U

// root table, VPN1 1 points down, 2 and 3 are megapages, 4 reads back an error
1 000100004 00040401 0 0 0 0 0
1 000100008 0AB000C7 0 0 0 0 0
1 00010000C 0AB004C7 0 0 0 0 0
1 000100010 00000000 1 0 0 0 0

// second level table, VPN0 1 to 7
1 000101004 048D14C7 0 0 0 0 0
1 000101008 000888D7 0 0 0 0 0
1 00010100C 000CCC47 0 0 0 0 0
1 000101010 00111049 0 0 0 0 0
1 000101014 001554C6 0 0 0 0 0
1 000101018 00199887 0 0 0 0 0
1 00010101C 00000000 1 0 0 0 0

// bare mode
2 00 01000 FFFFF004 0 0FFFFF004 000 0
2 01 01000 12345678 1 012345678 000 0
// 4 KiB walk and hit, megapages
2 02 11001 00401234 0 012345234 000 2
2 03 11000 00401ABC 0 012345ABC 000 0
2 04 11000 00812345 1 02AC12345 000 1
2 05 11000 00C00010 1 000000000 10F 1
// permission checks
2 06 11000 00402010 0 000000000 10D 2
2 07 11100 00402010 0 000222010 000 0
2 08 10000 00401000 1 000000000 10F 0
2 09 11000 00403008 1 000000000 10F 2
2 0A 11000 00403008 0 000333008 000 0
2 0B 11000 00404100 0 000000000 10D 2
2 0C 11010 00404100 0 000444100 000 0
2 0D 11000 00405000 0 000000000 10D 2
2 0E 11000 00406000 1 000000000 10F 2
// memory errors during a walk
2 0F 11000 00407000 0 000000000 105 2
2 10 11000 00407000 1 000000000 107 2
2 11 11000 01000000 1 000000000 107 1
2 12 11000 01400000 0 000000000 10D 1
// flush forces a new walk
2 13 11101 00402020 0 000222020 000 2
2 14 11100 00402FFC 0 000222FFC 000 0
2 15 11101 00402FFC 0 000222FFC 000 2
2 16 01000 00401234 0 000401234 000 0

// File: dv/tb_sv32_mmu.sv
// testbench for the Sv32 data MMU with page tables and vectors from dv/mmu_golden.hex
// run from the project root so the data file path resolves
// PTE latency and both ready inputs are drawn from one seeded $random stream
`timescale 1ns/1ps
`default_nettype none

module tb_sv32_mmu;
  import mmu_pkg::*;

  localparam int REC_WORDS = 8;
  localparam int MAX_RECS  = 64;
  localparam int MAX_MEM   = 32;
  localparam int TIMEOUT   = 200;
  localparam int NUM_NAMES = 23;
  localparam logic [PPNW-1:0] ROOT_PPN = 22'h00100;

  // --------------------
  // DUT signals
  // --------------------
  logic            clk_i;
  logic            rst_i;
  logic            xlate_en_i;
  logic [PPNW-1:0] satp_ppn_i;
  priv_lvl_e       priv_lvl_i;
  logic            sum_i;
  logic            mxr_i;
  logic            flush_tlb_i;
  logic            req_valid_i;
  logic [VLEN-1:0] req_vaddr_i;
  logic            req_store_i;
  logic            req_ready_o;
  logic            resp_valid_o;
  logic [PLEN-1:0] resp_paddr_o;
  logic            resp_exc_o;
  exc_cause_e      resp_cause_o;
  logic            resp_ready_i;
  logic            mem_req_valid_o;
  logic            mem_req_ready_i;
  logic [PLEN-1:0] mem_addr_o;
  logic            mem_rvalid_i;
  logic            mem_err_i;
  logic [31:0]     mem_rdata_i;

  // golden records of eight words each
  logic [35:0]     golden [REC_WORDS*MAX_RECS];
  // PTE memory built from kind 1 records
  logic [PLEN-1:0] mem_addr_tab [MAX_MEM];
  logic [31:0]     mem_data_tab [MAX_MEM];
  logic            mem_err_tab  [MAX_MEM];
  int              mem_entries;

  // memory model state
  logic            mem_pending;
  int              mem_delay;
  logic [PLEN-1:0] mem_rd_addr;
  int              mem_reqs;

  integer          seed = 32'h6c42397f;
  int              errors;
  int              tests;
  int              passed;
  int              failed;
  logic            timed_out;

  string test_names [NUM_NAMES] = '{
    "bare_load", "bare_store", "walk_4k_load", "hit_4k_load", "mega_store",
    "mega_misaligned", "upage_from_s_nosum", "upage_from_s_sum", "spage_from_u",
    "store_d_clear", "load_d_clear", "xonly_mxr_clear", "xonly_mxr_set",
    "invalid_pte", "a_clear", "l0_load_access", "l0_store_access",
    "l1_store_access", "unmapped_load", "flush_then_walk", "hit_after_walk",
    "flush_again_walk", "bare_after_walks"
  };

  sv32_mmu #(
    .TLB_ENTRIES (4)
  ) dut (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .xlate_en_i      (xlate_en_i),
    .satp_ppn_i      (satp_ppn_i),
    .priv_lvl_i      (priv_lvl_i),
    .sum_i           (sum_i),
    .mxr_i           (mxr_i),
    .flush_tlb_i     (flush_tlb_i),
    .req_valid_i     (req_valid_i),
    .req_vaddr_i     (req_vaddr_i),
    .req_store_i     (req_store_i),
    .req_ready_o     (req_ready_o),
    .resp_valid_o    (resp_valid_o),
    .resp_paddr_o    (resp_paddr_o),
    .resp_exc_o      (resp_exc_o),
    .resp_cause_o    (resp_cause_o),
    .resp_ready_i    (resp_ready_i),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_addr_o      (mem_addr_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_err_i       (mem_err_i),
    .mem_rdata_i     (mem_rdata_i)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  function automatic string test_name(int idx);
    string name;
    name = "unknown";
    if (idx >= 0 && idx < NUM_NAMES) name = test_names[idx];
    return name;
  endfunction

  // unlisted addresses read back as zero, which is an invalid PTE
  function automatic int find_pte(logic [PLEN-1:0] addr);
    int slot;
    slot = -1;
    for (int i = 0; i < mem_entries; i++) begin
      if (mem_addr_tab[i] == addr) slot = i;
    end
    return slot;
  endfunction

  // --------------------
  // memory model
  // --------------------
  // one falling edge answers a pending PTE read, redraws both readies and catches new reads
  task automatic tick();
    logic [31:0] rnd;
    int          slot;
    @(negedge clk_i);
    mem_rvalid_i = 1'b0;
    mem_err_i    = 1'b0;
    mem_rdata_i  = '0;
    if (mem_pending) begin
      if (mem_delay == 0) begin
        slot         = find_pte(mem_rd_addr);
        mem_rvalid_i = 1'b1;
        if (slot >= 0) begin
          mem_rdata_i = mem_data_tab[slot];
          mem_err_i   = mem_err_tab[slot];
        end
        mem_pending = 1'b0;
      end else begin
        mem_delay = mem_delay - 1;
      end
    end
    rnd = $random(seed);
    // PTE port ready three times in four and response ready half the time
    mem_req_ready_i = |rnd[1:0];
    resp_ready_i    = rnd[2];
    // valid is stable here, so a handshake lands on the next rising edge
    if (mem_req_valid_o && mem_req_ready_i) begin
      mem_pending = 1'b1;
      mem_delay   = int'(rnd[5:4]);
      mem_rd_addr = mem_addr_o;
      mem_reqs    = mem_reqs + 1;
    end
  endtask

  // --------------------
  // vector driver and checker
  // --------------------
  task automatic run_vector(int base);
    logic [35:0]     ctrl;
    logic [35:0]     expw;
    logic [VLEN-1:0] vaddr;
    logic            store;
    logic [PLEN-1:0] exp_paddr;
    logic            exp_exc;
    logic [4:0]      exp_cause;
    int              exp_reqs;
    int              wait_cnt;
    int              errs_before;
    logic            got;
    logic            seen;
    logic [PLEN-1:0] held_paddr;
    logic            held_exc;
    logic [4:0]      held_cause;
    string           name;
    name        = test_name(int'(golden[base+1]));
    ctrl        = golden[base+2];
    vaddr       = golden[base+3][VLEN-1:0];
    store       = golden[base+4][0];
    exp_paddr   = golden[base+5][PLEN-1:0];
    expw        = golden[base+6];
    exp_exc     = expw[8];
    exp_cause   = expw[4:0];
    exp_reqs    = int'(golden[base+7]);
    errs_before = errors;
    held_paddr  = '0;
    held_exc    = 1'b0;
    held_cause  = '0;
    tests       = tests + 1;

    // controls stay put for the whole request and flush is a one cycle pulse
    tick();
    xlate_en_i  = ctrl[16];
    priv_lvl_i  = priv_lvl_e'(ctrl[13:12]);
    sum_i       = ctrl[8];
    mxr_i       = ctrl[4];
    flush_tlb_i = ctrl[0];
    tick();
    flush_tlb_i = 1'b0;
    mem_reqs    = 0;

    req_valid_i = 1'b1;
    req_vaddr_i = vaddr;
    req_store_i = store;
    wait_cnt    = 0;
    while (!req_ready_o && wait_cnt < TIMEOUT) begin
      tick();
      wait_cnt++;
    end
    if (!req_ready_o) begin
      $display("%s: request was not accepted within %0d cycles", name, TIMEOUT);
      req_valid_i = 1'b0;
      timed_out   = 1'b1;
      failed      = failed + 1;
      return;
    end

    // accepted on the rising edge just passed
    tick();
    req_valid_i = 1'b0;
    // bare mode and TLB hits answer in the cycle after acceptance
    if (exp_reqs == 0 && resp_valid_o !== 1'b1) begin
      $display("%s: no response in the cycle after the request was accepted", name);
      errors = errors + 1;
    end
    got         = 1'b0;
    seen        = 1'b0;
    wait_cnt    = 0;
    while (!got && wait_cnt < TIMEOUT) begin
      if (resp_valid_o) begin
        // a stalled response must not move
        if (seen && (resp_paddr_o !== held_paddr || resp_exc_o !== held_exc ||
                     resp_cause_o !== held_cause)) begin
          $display("[ERROR] %s: stalled response changed, expected %h/%b/%0d actual %h/%b/%0d",
                   name, held_paddr, held_exc, held_cause,
                   resp_paddr_o, resp_exc_o, resp_cause_o);
          errors = errors + 1;
        end
        seen       = 1'b1;
        held_paddr = resp_paddr_o;
        held_exc   = resp_exc_o;
        held_cause = resp_cause_o;
        if (resp_ready_i) got = 1'b1;
      end else if (seen) begin
        $display("%s: response valid dropped before the response was accepted", name);
        errors = errors + 1;
        seen   = 1'b0;
      end
      if (!got) begin
        tick();
        wait_cnt++;
      end
    end
    if (!got) begin
      $display("%s: no response within %0d cycles", name, TIMEOUT);
      timed_out = 1'b1;
      failed    = failed + 1;
      return;
    end

    if (held_paddr !== exp_paddr) begin
      $display("[ERROR] %s: paddr expected %h actual %h", name, exp_paddr, held_paddr);
      errors = errors + 1;
    end
    if (held_exc !== exp_exc) begin
      $display("[ERROR] %s: exception expected %b actual %b", name, exp_exc, held_exc);
      errors = errors + 1;
    end
    // cause only carries meaning with an exception
    if (exp_exc && held_cause !== exp_cause) begin
      $display("[ERROR] %s: cause expected %0d actual %0d", name, exp_cause, held_cause);
      errors = errors + 1;
    end
    if (mem_reqs != exp_reqs) begin
      $display("[ERROR] %s: memory requests expected %0d actual %0d", name, exp_reqs, mem_reqs);
      errors = errors + 1;
    end
    if (errors == errs_before) begin
      passed = passed + 1;
      $display("test %s: ok", name);
    end else begin
      failed = failed + 1;
      $display("test %s: mismatch", name);
    end
  endtask

  // --------------------
  // main sequence
  // --------------------
  initial begin
    int errs_before;
    rst_i           = 1'b1;
    xlate_en_i      = 1'b0;
    satp_ppn_i      = ROOT_PPN;
    priv_lvl_i      = PRIV_S;
    sum_i           = 1'b0;
    mxr_i           = 1'b0;
    flush_tlb_i     = 1'b0;
    req_valid_i     = 1'b0;
    req_vaddr_i     = '0;
    req_store_i     = 1'b0;
    resp_ready_i    = 1'b0;
    mem_req_ready_i = 1'b0;
    mem_rvalid_i    = 1'b0;
    mem_err_i       = 1'b0;
    mem_rdata_i     = '0;
    mem_pending     = 1'b0;
    mem_delay       = 0;
    mem_rd_addr     = '0;
    mem_reqs        = 0;
    mem_entries     = 0;
    errors          = 0;
    tests           = 0;
    passed          = 0;
    failed          = 0;
    timed_out       = 1'b0;

    // kind 0 marks an unused record slot
    for (int i = 0; i < REC_WORDS*MAX_RECS; i++) golden[i] = '0;
    $readmemh("dv/mmu_golden.hex", golden);
    for (int r = 0; r < MAX_RECS; r++) begin
      if (golden[r*REC_WORDS] == 36'd1 && mem_entries < MAX_MEM) begin
        mem_addr_tab[mem_entries] = golden[r*REC_WORDS+1][PLEN-1:0];
        mem_data_tab[mem_entries] = golden[r*REC_WORDS+2][31:0];
        mem_err_tab[mem_entries]  = golden[r*REC_WORDS+3][0];
        mem_entries               = mem_entries + 1;
      end
    end

    repeat (16) @(negedge clk_i);
    rst_i = 1'b0;

    // idle state straight out of reset
    errs_before = errors;
    tests       = tests + 1;
    if (req_ready_o !== 1'b1 || resp_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0) begin
      $display("[ERROR] reset_state: ready/resp_valid/mem_valid expected 100 actual %b%b%b",
               req_ready_o, resp_valid_o, mem_req_valid_o);
      errors = errors + 1;
    end
    if (errors == errs_before) begin
      passed = passed + 1;
      $display("test reset_state: ok");
    end else begin
      failed = failed + 1;
      $display("test reset_state: mismatch");
    end

    for (int r = 0; r < MAX_RECS; r++) begin
      if (golden[r*REC_WORDS] == 36'd2 && !timed_out) run_vector(r*REC_WORDS);
    end

    $display("tests %0d, passed %0d, failed %0d, check errors %0d",
             tests, passed, failed, errors);
    if (errors == 0 && failed == 0 && !timed_out) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: sim.f
src/mmu_pkg.sv
src/sv32_dtlb.sv
src/sv32_ptw.sv
src/lsu_xlate.sv
src/sv32_mmu.sv
dv/tb_sv32_mmu.sv

// File: src/lsu_xlate.sv
// load/store translation stage, one request in flight
// xlate_en_i, priv and SUM/MXR are sampled each cycle, keep them stable per request
// resp_cause_o only carries meaning while resp_exc_o is high
`timescale 1ns/1ps
`default_nettype none

module lsu_xlate (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // control
  input  logic                     xlate_en_i,
  input  mmu_pkg::priv_lvl_e       priv_lvl_i,
  input  logic                     sum_i,
  input  logic                     mxr_i,
  // request channel
  input  logic                     req_valid_i,
  input  logic [mmu_pkg::VLEN-1:0] req_vaddr_i,
  input  logic                     req_store_i,
  output logic                     req_ready_o,
  // response channel
  output logic                     resp_valid_o,
  output logic [mmu_pkg::PLEN-1:0] resp_paddr_o,
  output logic                     resp_exc_o,
  output mmu_pkg::exc_cause_e      resp_cause_o,
  input  logic                     resp_ready_i,
  // TLB lookup
  output logic [mmu_pkg::VLEN-1:0] lu_vaddr_o,
  input  logic                     lu_hit_i,
  input  logic [31:0]              lu_pte_i,
  input  logic                     lu_mega_i,
  // walker
  output logic                     walk_req_o,
  output logic [mmu_pkg::VLEN-1:0] walk_vaddr_o,
  input  logic                     walk_done_i,
  input  logic                     walk_pf_i,
  input  logic                     walk_af_i
);
  import mmu_pkg::*;

  // request state
  logic            busy_q;
  logic [VLEN-1:0] vaddr_q;
  logic            store_q;
  // walk fault seen for this request
  logic            wpf_q;
  logic            waf_q;
  // response stalled by the consumer
  logic            hold_q;
  logic [PLEN-1:0] hold_paddr_q;
  logic            hold_exc_q;
  exc_cause_e      hold_cause_q;

  logic            priv_err;
  logic            perm_ok;
  logic            live_valid;
  logic            live_exc;
  logic [PLEN-1:0] live_paddr;
  exc_cause_e      live_cause;
  logic            resp_fire;

  // --------------------
  // permission check
  // --------------------
  always_comb begin
    // user page from S needs SUM, supervisor page never reachable from U
    priv_err = ((priv_lvl_i == PRIV_U) && !lu_pte_i[PTE_U]) ||
               ((priv_lvl_i == PRIV_S) && lu_pte_i[PTE_U] && !sum_i);
    if (store_q) begin
      perm_ok = lu_pte_i[PTE_W] && lu_pte_i[PTE_D];
    end else begin
      // MXR makes execute-only pages readable
      perm_ok = lu_pte_i[PTE_R] || (lu_pte_i[PTE_X] && mxr_i);
    end
  end

  // --------------------
  // live response
  // --------------------
  always_comb begin
    live_valid = 1'b0;
    live_exc   = 1'b0;
    live_cause = store_q ? STORE_PAGE_FAULT : LOAD_PAGE_FAULT;
    // bare mode pass-through
    live_paddr = {{(PLEN-VLEN){1'b0}}, vaddr_q};
    if (!xlate_en_i) begin
      live_valid = busy_q;
    end else if (waf_q) begin
      live_valid = busy_q;
      live_exc   = 1'b1;
      live_cause = store_q ? ST_ACCESS_FAULT : LD_ACCESS_FAULT;
    end else if (wpf_q) begin
      live_valid = busy_q;
      live_exc   = 1'b1;
    end else if (lu_hit_i) begin
      live_valid = busy_q;
      live_exc   = priv_err || !perm_ok;
      if (lu_mega_i) begin
        // PPN1 plus 22 bits of vaddr
        live_paddr = {lu_pte_i[PTE_PPN_LSB+VPNW +: PPNW-VPNW], vaddr_q[VPNW+PAGE_OFFW-1:0]};
      end else begin
        live_paddr = {lu_pte_i[PTE_PPN_LSB +: PPNW], vaddr_q[PAGE_OFFW-1:0]};
      end
    end
    // no address leaks out with a fault
    if (live_exc) live_paddr = '0;
  end

  // held copy wins once the consumer has stalled
  assign resp_valid_o = hold_q || live_valid;
  assign resp_paddr_o = hold_q ? hold_paddr_q : live_paddr;
  assign resp_exc_o   = hold_q ? hold_exc_q : live_exc;
  assign resp_cause_o = hold_q ? hold_cause_q : live_cause;
  assign resp_fire    = resp_valid_o && resp_ready_i;

  assign req_ready_o  = !busy_q;
  assign lu_vaddr_o   = vaddr_q;
  assign walk_vaddr_o = vaddr_q;
  // level request, drops on the cycle a result is available
  assign walk_req_o   = busy_q && !hold_q && !live_valid;

  // --------------------
  // control state
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      busy_q <= 1'b0;
      hold_q <= 1'b0;
      wpf_q  <= 1'b0;
      waf_q  <= 1'b0;
    end else if (resp_fire) begin
      busy_q <= 1'b0;
      hold_q <= 1'b0;
      wpf_q  <= 1'b0;
      waf_q  <= 1'b0;
    end else begin
      if (req_valid_i && req_ready_o) busy_q <= 1'b1;
      // freeze the response until it is taken
      if (live_valid) hold_q <= 1'b1;
      if (walk_done_i && walk_req_o) begin
        wpf_q <= walk_pf_i;
        waf_q <= walk_af_i;
      end
    end
  end

  // request and response payload
  always_ff @(posedge clk_i) begin
    if (req_valid_i && req_ready_o) begin
      vaddr_q <= req_vaddr_i;
      store_q <= req_store_i;
    end
    if (!hold_q) begin
      hold_paddr_q <= live_paddr;
      hold_exc_q   <= live_exc;
      hold_cause_q <= live_cause;
    end
  end

endmodule

`default_nettype wire

// File: src/mmu_pkg.sv
// widths, PTE layout and encodings shared by the Sv32 data MMU
// only U and S privilege are modelled, M mode is expected to run with xlate_en_i low
// G bit and RSW field of a PTE are ignored
`default_nettype none

package mmu_pkg;

  // --------------------
  // address widths
  // --------------------
  localparam int unsigned VLEN      = 32;
  localparam int unsigned PLEN      = 34;
  localparam int unsigned PPNW      = 22;
  // one VPN field, two of them make the full VPN
  localparam int unsigned VPNW      = 10;
  localparam int unsigned PAGE_OFFW = 12;

  // --------------------
  // PTE flag bit positions
  // --------------------
  localparam int unsigned PTE_V       = 0;
  localparam int unsigned PTE_R       = 1;
  localparam int unsigned PTE_W       = 2;
  localparam int unsigned PTE_X       = 3;
  localparam int unsigned PTE_U       = 4;
  // bit 5 is G, not used here
  localparam int unsigned PTE_A       = 6;
  localparam int unsigned PTE_D       = 7;
  // PPN sits above the two RSW bits
  localparam int unsigned PTE_PPN_LSB = 10;

  // privilege of the load/store access
  typedef enum logic [1:0] {
    PRIV_U = 2'b00,
    PRIV_S = 2'b01
  } priv_lvl_e;

  // mcause codes raised by the data side
  typedef enum logic [4:0] {
    LD_ACCESS_FAULT  = 5'd5,
    ST_ACCESS_FAULT  = 5'd7,
    LOAD_PAGE_FAULT  = 5'd13,
    STORE_PAGE_FAULT = 5'd15
  } exc_cause_e;

  // page table walker states
  typedef enum logic [2:0] {
    IDLE,
    REQ_L1,
    WAIT_L1,
    REQ_L0,
    WAIT_L0,
    DONE
  } ptw_state_e;

endpackage

`default_nettype wire

// File: src/sv32_dtlb.sv
// fully associative data TLB, no ASID, global flush only
// lookup is combinational, a fill shows up on the following cycle
// a flush in the same cycle as a fill wins, the fill is dropped
`timescale 1ns/1ps
`default_nettype none

module sv32_dtlb #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  input  logic                     flush_i,
  // lookup port
  input  logic [mmu_pkg::VLEN-1:0] lu_vaddr_i,
  output logic                     lu_hit_o,
  output logic [31:0]              lu_pte_o,
  output logic                     lu_mega_o,
  // fill port from the walker
  input  logic                     fill_i,
  input  logic [2*mmu_pkg::VPNW-1:0] fill_vpn_i,
  input  logic [31:0]              fill_pte_i,
  input  logic                     fill_mega_i
);
  import mmu_pkg::*;

  localparam int unsigned IDXW = $clog2(TLB_ENTRIES);

  // entry storage
  logic [TLB_ENTRIES-1:0] valid_q;
  logic [TLB_ENTRIES-1:0] mega_q;
  logic [VPNW-1:0]        vpn1_q [TLB_ENTRIES];
  logic [VPNW-1:0]        vpn0_q [TLB_ENTRIES];
  logic [31:0]            pte_q  [TLB_ENTRIES];

  // replacement
  logic [IDXW-1:0]        rr_q;
  logic [IDXW-1:0]        fill_idx;
  logic                   free_found;

  // --------------------
  // lookup
  // --------------------
  // a fill only follows a miss, so at most one entry matches
  always_comb begin
    lu_hit_o  = 1'b0;
    lu_pte_o  = '0;
    lu_mega_o = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      // megapage entries ignore VPN0
      if (valid_q[i] && (vpn1_q[i] == lu_vaddr_i[VLEN-1 -: VPNW]) &&
          (mega_q[i] || (vpn0_q[i] == lu_vaddr_i[PAGE_OFFW +: VPNW]))) begin
        lu_hit_o  = 1'b1;
        lu_pte_o  = pte_q[i];
        lu_mega_o = mega_q[i];
      end
    end
  end

  // --------------------
  // victim select
  // --------------------
  // lowest free slot first, round robin once the table is full
  always_comb begin
    fill_idx   = rr_q;
    free_found = 1'b0;
    for (int i = 0; i < TLB_ENTRIES; i++) begin
      if (!valid_q[i] && !free_found) begin
        fill_idx   = IDXW'(i);
        free_found = 1'b1;
      end
    end
  end

  // valid bits and pointer
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      valid_q <= '0;
      rr_q    <= '0;
    end else if (flush_i) begin
      valid_q <= '0;
    end else if (fill_i) begin
      valid_q[fill_idx] <= 1'b1;
      // pointer only moves when an entry gets evicted
      if (!free_found) begin
        rr_q <= (rr_q == IDXW'(TLB_ENTRIES - 1)) ? '0 : rr_q + 1'b1;
      end
    end
  end

  // entry payload
  always_ff @(posedge clk_i) begin
    if (fill_i) begin
      vpn1_q[fill_idx] <= fill_vpn_i[2*VPNW-1:VPNW];
      vpn0_q[fill_idx] <= fill_vpn_i[VPNW-1:0];
      mega_q[fill_idx] <= fill_mega_i;
      pte_q[fill_idx]  <= fill_pte_i;
    end
  end

endmodule

`default_nettype wire

// File: src/sv32_mmu.sv
// data side Sv32 MMU top, 4 KiB and 4 MiB pages, no ASID and no PMP
// one translation in flight, control inputs stay stable while busy
`timescale 1ns/1ps
`default_nettype none

module sv32_mmu #(
  parameter int unsigned TLB_ENTRIES = 4
) (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // control
  input  logic                     xlate_en_i,
  input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
  input  mmu_pkg::priv_lvl_e       priv_lvl_i,
  input  logic                     sum_i,
  input  logic                     mxr_i,
  input  logic                     flush_tlb_i,
  // request
  input  logic                     req_valid_i,
  input  logic [mmu_pkg::VLEN-1:0] req_vaddr_i,
  input  logic                     req_store_i,
  output logic                     req_ready_o,
  // response
  output logic                     resp_valid_o,
  output logic [mmu_pkg::PLEN-1:0] resp_paddr_o,
  output logic                     resp_exc_o,
  output mmu_pkg::exc_cause_e      resp_cause_o,
  input  logic                     resp_ready_i,
  // PTE memory
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output logic [mmu_pkg::PLEN-1:0] mem_addr_o,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_err_i,
  input  logic [31:0]              mem_rdata_i
);
  import mmu_pkg::*;

  // --------------------
  // lookup path
  // --------------------
  logic [VLEN-1:0]   lu_vaddr;
  logic              lu_hit;
  logic [31:0]       lu_pte;
  logic              lu_mega;

  // walk handshake
  logic              walk_req;
  logic [VLEN-1:0]   walk_vaddr;
  logic              walk_done;
  logic              walk_pf;
  logic              walk_af;

  // walker to TLB fill
  logic              fill;
  logic [2*VPNW-1:0] fill_vpn;
  logic [31:0]       fill_pte;
  logic              fill_mega;

  lsu_xlate i_xlate (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .xlate_en_i   (xlate_en_i),
    .priv_lvl_i   (priv_lvl_i),
    .sum_i        (sum_i),
    .mxr_i        (mxr_i),
    .req_valid_i  (req_valid_i),
    .req_vaddr_i  (req_vaddr_i),
    .req_store_i  (req_store_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .resp_paddr_o (resp_paddr_o),
    .resp_exc_o   (resp_exc_o),
    .resp_cause_o (resp_cause_o),
    .resp_ready_i (resp_ready_i),
    .lu_vaddr_o   (lu_vaddr),
    .lu_hit_i     (lu_hit),
    .lu_pte_i     (lu_pte),
    .lu_mega_i    (lu_mega),
    .walk_req_o   (walk_req),
    .walk_vaddr_o (walk_vaddr),
    .walk_done_i  (walk_done),
    .walk_pf_i    (walk_pf),
    .walk_af_i    (walk_af)
  );

  sv32_dtlb #(
    .TLB_ENTRIES (TLB_ENTRIES)
  ) i_dtlb (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_tlb_i),
    .lu_vaddr_i  (lu_vaddr),
    .lu_hit_o    (lu_hit),
    .lu_pte_o    (lu_pte),
    .lu_mega_o   (lu_mega),
    .fill_i      (fill),
    .fill_vpn_i  (fill_vpn),
    .fill_pte_i  (fill_pte),
    .fill_mega_i (fill_mega)
  );

  // walker reads PTEs straight off the outside memory port
  sv32_ptw i_ptw (
    .clk_i           (clk_i),
    .rst_i           (rst_i),
    .walk_req_i      (walk_req),
    .walk_vaddr_i    (walk_vaddr),
    .satp_ppn_i      (satp_ppn_i),
    .walk_done_o     (walk_done),
    .walk_pf_o       (walk_pf),
    .walk_af_o       (walk_af),
    .fill_o          (fill),
    .fill_vpn_o      (fill_vpn),
    .fill_pte_o      (fill_pte),
    .fill_mega_o     (fill_mega),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_addr_o      (mem_addr_o),
    .mem_rvalid_i    (mem_rvalid_i),
    .mem_err_i       (mem_err_i),
    .mem_rdata_i     (mem_rdata_i)
  );

endmodule

`default_nettype wire

// File: src/sv32_ptw.sv
// two level Sv32 walker with one memory read in flight at a time
// walk_req_i and walk_vaddr_i must hold until walk_done_o
// A and D are never written back so a leaf with A clear is a page fault
`timescale 1ns/1ps
`default_nettype none

module sv32_ptw (
  input  logic                     clk_i,
  input  logic                     rst_i,
  // walk request from the translation stage
  input  logic                     walk_req_i,
  input  logic [mmu_pkg::VLEN-1:0] walk_vaddr_i,
  input  logic [mmu_pkg::PPNW-1:0] satp_ppn_i,
  output logic                     walk_done_o,
  output logic                     walk_pf_o,
  output logic                     walk_af_o,
  // TLB fill
  output logic                     fill_o,
  output logic [2*mmu_pkg::VPNW-1:0] fill_vpn_o,
  output logic [31:0]              fill_pte_o,
  output logic                     fill_mega_o,
  // PTE read port
  output logic                     mem_req_valid_o,
  input  logic                     mem_req_ready_i,
  output logic [mmu_pkg::PLEN-1:0] mem_addr_o,
  input  logic                     mem_rvalid_i,
  input  logic                     mem_err_i,
  input  logic [31:0]              mem_rdata_i
);
  import mmu_pkg::*;

  ptw_state_e          state_q;
  logic                pf_q;
  logic                af_q;

  // walk payload
  logic [2*VPNW-1:0]   vpn_q;
  logic [31:0]         pte_q;
  logic                mega_q;

  // decode of the PTE on the read data bus
  logic                pte_ok;
  logic                pte_leaf;
  logic                pte_misaligned;

  // V clear or W without R is reserved
  assign pte_ok   = mem_rdata_i[PTE_V] && !(mem_rdata_i[PTE_W] && !mem_rdata_i[PTE_R]);
  assign pte_leaf = mem_rdata_i[PTE_R] || mem_rdata_i[PTE_X];
  // superpage leaf needs PPN0 of zero
  assign pte_misaligned = |mem_rdata_i[PTE_PPN_LSB +: VPNW];

  // --------------------
  // walk FSM
  // --------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state_q <= IDLE;
      pf_q    <= 1'b0;
      af_q    <= 1'b0;
    end else begin
      case (state_q)
        IDLE: begin
          if (walk_req_i) begin
            pf_q    <= 1'b0;
            af_q    <= 1'b0;
            state_q <= REQ_L1;
          end
        end
        REQ_L1: begin
          if (mem_req_ready_i) state_q <= WAIT_L1;
        end
        WAIT_L1: begin
          if (mem_rvalid_i) begin
            if (mem_err_i) begin
              af_q    <= 1'b1;
              state_q <= DONE;
            end else if (!pte_ok) begin
              pf_q    <= 1'b1;
              state_q <= DONE;
            end else if (pte_leaf) begin
              // megapage leaf ends the walk here
              pf_q    <= pte_misaligned || !mem_rdata_i[PTE_A];
              state_q <= DONE;
            end else begin
              // pointer to the next level table
              state_q <= REQ_L0;
            end
          end
        end
        REQ_L0: begin
          if (mem_req_ready_i) state_q <= WAIT_L0;
        end
        WAIT_L0: begin
          if (mem_rvalid_i) begin
            af_q    <= mem_err_i;
            // last level must be a leaf
            pf_q    <= !mem_err_i && (!pte_ok || !pte_leaf || !mem_rdata_i[PTE_A]);
            state_q <= DONE;
          end
        end
        DONE: begin
          state_q <= IDLE;
        end
        default: begin
          state_q <= IDLE;
        end
      endcase
    end
  end

  // vpn and last PTE of the walk
  always_ff @(posedge clk_i) begin
    if ((state_q == IDLE) && walk_req_i) begin
      vpn_q <= walk_vaddr_i[VLEN-1:PAGE_OFFW];
    end
    if ((state_q == WAIT_L1) && mem_rvalid_i) begin
      pte_q  <= mem_rdata_i;
      mega_q <= 1'b1;
    end
    if ((state_q == WAIT_L0) && mem_rvalid_i) begin
      pte_q  <= mem_rdata_i;
      mega_q <= 1'b0;
    end
  end

  // --------------------
  // memory address
  // --------------------
  // level 0 reuses the PPN of the stored pointer PTE
  always_comb begin
    if (state_q == REQ_L0) begin
      mem_addr_o = {pte_q[PTE_PPN_LSB +: PPNW], vpn_q[VPNW-1:0], 2'b00};
    end else begin
      mem_addr_o = {satp_ppn_i, vpn_q[2*VPNW-1:VPNW], 2'b00};
    end
  end

  assign mem_req_valid_o = (state_q == REQ_L1) || (state_q == REQ_L0);

  // results are all qualified by walk_done_o
  assign walk_done_o = (state_q == DONE);
  assign walk_pf_o   = pf_q;
  assign walk_af_o   = af_q;
  // fill only on a clean walk
  assign fill_o      = (state_q == DONE) && !pf_q && !af_q;
  assign fill_vpn_o  = vpn_q;
  assign fill_pte_o  = pte_q;
  assign fill_mega_o = mega_q;

endmodule

`default_nettype wire
